//--- common/fsmc_pkg.sv
// ======================================================================
// fsmc shared definitions
// bus widths, target and direction encodings, host request bundle
// ======================================================================

package fsmc_pkg;

    // ==================================================================
    // widths
    // ==================================================================
    localparam int FSMC_DATA_WIDTH       = 16;  // data word on AD[15:0]
    localparam int FSMC_CS_COUNT         = 4;   // one-hot targets behind the decoder
    localparam int FSMC_FIFO_LEVEL_WIDTH = 8;   // level field in the status word

    // direction latched at the address phase, taken from the nwe level
    typedef enum logic {
        DIR_WRITE = 1'b0,   // nwe low while nadv high-going
        DIR_READ  = 1'b1
    } fsmc_dir_e;

    // target number from AD[1:0]
    typedef enum logic [1:0] {
        TGT_SCRATCH = 2'd0,  // plain r/w word
        TGT_CONTROL = 2'd1,  // bit 0 = mailbox enable
        TGT_STATUS  = 2'd2,  // level + sticky overflow, write clears
        TGT_MAILBOX = 2'd3   // fifo push / pop
    } fsmc_target_e;

    // ==================================================================
    // request from the bus interface to the register bank
    // ==================================================================
    typedef struct packed {
        logic [FSMC_CS_COUNT-1:0]   cs;         // one-hot select, zero when idle
        fsmc_dir_e                  dir;        // access direction
        logic [FSMC_DATA_WIDTH-1:0] wdata;      // write word
        logic                       wr_strobe;  // one cycle, write data valid
        logic                       rd_done;    // one cycle, read finished
    } fsmc_host_req_t;  // 23 bits

endpackage

//--- fsmc/fsmc_interface.sv
// ======================================================================
// fsmc multiplexed nor/psram bus interface
// latches address and direction, decodes chip selects, makes the
// write strobe and read completion pulse, drives AD during reads
// ======================================================================

`timescale 1ns/1ps

module fsmc_interface #(
    parameter int                    ADDR_WIDTH       = 18,
    parameter logic [ADDR_WIDTH-3:0] HIGH_ADDR_CS     = 16'h0040,
    parameter int                    DATA_HOLD_CYCLES = 2
) (
    inout  wire  [ADDR_WIDTH-1:0]               ad,       // muxed address / data
    input  logic                                nadv,     // address valid, active low
    input  logic                                nwe,      // write enable, active low
    input  logic                                noe,      // output enable, active low
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic [fsmc_pkg::FSMC_DATA_WIDTH-1:0] host_rdata,
    output fsmc_pkg::fsmc_host_req_t            host_req
);

    import fsmc_pkg::*;

    localparam int HOLD_W = $clog2(DATA_HOLD_CYCLES + 1);

    typedef enum logic [1:0] {
        RD_IDLE,    // AD released
        RD_DRIVE,   // noe low, driving host_rdata
        RD_HOLD     // noe back high, holding data a few cycles
    } rd_state_e;

    // ==================================================================
    // strobe edge detection
    // ==================================================================
    logic prev_nadv, prev_nwe, prev_noe;
    logic nadv_rise, nwe_rise, noe_rise;
    logic [1:0] nwe_rise_q;     // nwe rise delayed two cycles

    assign nadv_rise = ~prev_nadv & nadv;
    assign nwe_rise  = ~prev_nwe & nwe;
    assign noe_rise  = ~prev_noe & noe;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prev_nadv  <= 1'b1;
            prev_nwe   <= 1'b1;
            prev_noe   <= 1'b1;
            nwe_rise_q <= '0;
        end else begin
            prev_nadv  <= nadv;
            prev_nwe   <= nwe;
            prev_noe   <= noe;
            nwe_rise_q <= {nwe_rise_q[0], nwe_rise};
        end
    end

    // ==================================================================
    // address latch, chip select, write capture
    // ==================================================================
    logic [FSMC_CS_COUNT-1:0]   cs_q;       // live select
    logic [FSMC_CS_COUNT-1:0]   done_cs_q;  // select of the access just finished
    fsmc_dir_e                  dir_q;
    logic [FSMC_DATA_WIDTH-1:0] wdata_q;    // payload, no reset
    logic                       wr_strobe_q;
    logic                       rd_done_q;
    logic                       addr_hit;
    logic                       wr_fire;
    logic                       rd_finish;

    assign addr_hit = (ad[ADDR_WIDTH-1:2] == HIGH_ADDR_CS);
    assign wr_fire  = nwe_rise_q[1] && (dir_q == DIR_WRITE) && (|cs_q);

    always_ff @(posedge clk) begin
        if (nadv_rise || wr_fire)
            wdata_q <= ad[FSMC_DATA_WIDTH-1:0];   // address word, then write word
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cs_q        <= '0;
            done_cs_q   <= '0;
            dir_q       <= DIR_WRITE;
            wr_strobe_q <= 1'b0;
            rd_done_q   <= 1'b0;
        end else begin
            wr_strobe_q <= wr_fire;
            rd_done_q   <= rd_finish;
            if (nadv_rise) begin
                dir_q <= nwe ? DIR_READ : DIR_WRITE;   // nwe high means read
                cs_q  <= addr_hit ? FSMC_CS_COUNT'(1 << ad[1:0]) : '0;
            end else if (wr_fire || rd_finish) begin
                done_cs_q <= cs_q;    // keep old select for the pulse cycle
                cs_q      <= '0;
            end
        end
    end

    // ==================================================================
    // read drive sequencing
    // ==================================================================
    rd_state_e         rd_state;
    logic [HOLD_W-1:0] hold_cnt;

    assign rd_finish = (rd_state == RD_HOLD) && (hold_cnt == '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state <= RD_IDLE;
            hold_cnt <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if ((dir_q == DIR_READ) && (|cs_q) && !noe)
                        rd_state <= RD_DRIVE;
                end
                RD_DRIVE: begin
                    if (noe_rise) begin
                        rd_state <= RD_HOLD;
                        hold_cnt <= HOLD_W'(DATA_HOLD_CYCLES - 1);
                    end
                end
                RD_HOLD: begin
                    if (hold_cnt == '0)
                        rd_state <= RD_IDLE;   // drive ends, rd_done follows
                    else
                        hold_cnt <= hold_cnt - 1'b1;
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // upper AD bits read back as zero
    assign ad = (rd_state != RD_IDLE) ?
                {{(ADDR_WIDTH-FSMC_DATA_WIDTH){1'b0}}, host_rdata} :
                {ADDR_WIDTH{1'bz}};

    // ==================================================================
    // request to the register bank
    // ==================================================================
    always_comb begin
        host_req.cs        = (wr_strobe_q || rd_done_q) ? done_cs_q : cs_q;
        host_req.dir       = dir_q;
        host_req.wdata     = wdata_q;
        host_req.wr_strobe = wr_strobe_q;
        host_req.rd_done   = rd_done_q;
    end

endmodule

//--- rtl/fsmc_reg_bank.sv
// ======================================================================
// fsmc register bank
// scratch, control and status registers, mailbox push/pop control
// and the read word mux for the four targets
// ======================================================================

`timescale 1ns/1ps

module fsmc_reg_bank #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  fsmc_pkg::fsmc_host_req_t                   host_req,
    output logic [fsmc_pkg::FSMC_DATA_WIDTH-1:0]       host_rdata,
    output logic                                       fifo_push,
    output logic                                       fifo_pop,
    output logic [fsmc_pkg::FSMC_DATA_WIDTH-1:0]       fifo_wdata,
    input  logic [fsmc_pkg::FSMC_DATA_WIDTH-1:0]       fifo_rdata,
    input  logic [fsmc_pkg::FSMC_FIFO_LEVEL_WIDTH-1:0] fifo_level,
    input  logic                                       fifo_full,
    input  logic                                       fifo_empty
);

    import fsmc_pkg::*;

    // only as many level bits as the fifo can count
    localparam int LEVEL_BITS = $clog2(FIFO_DEPTH + 1);
    localparam logic [FSMC_FIFO_LEVEL_WIDTH-1:0] LEVEL_MASK =
        FSMC_FIFO_LEVEL_WIDTH'((1 << LEVEL_BITS) - 1);

    logic [FSMC_DATA_WIDTH-1:0]       scratch_q;
    logic [FSMC_DATA_WIDTH-1:0]       control_q;
    logic                             overflow_q;     // sticky
    logic                             wr_en, rd_en;
    logic                             mbox_en;
    logic                             mbox_wr;
    logic [FSMC_FIFO_LEVEL_WIDTH-1:0] level_field;
    logic [FSMC_DATA_WIDTH-1:0]       status_word;

    // ==================================================================
    // access qualification
    // ==================================================================
    assign wr_en   = host_req.wr_strobe && (host_req.dir == DIR_WRITE);
    assign rd_en   = host_req.rd_done && (host_req.dir == DIR_READ);
    assign mbox_en = control_q[0];
    assign mbox_wr = wr_en && host_req.cs[TGT_MAILBOX] && mbox_en;

    // mailbox traffic, full push and empty pop never reach the fifo
    assign fifo_push  = mbox_wr && !fifo_full;
    assign fifo_pop   = rd_en && host_req.cs[TGT_MAILBOX] && mbox_en && !fifo_empty;
    assign fifo_wdata = host_req.wdata;

    // ==================================================================
    // register writes
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scratch_q  <= '0;
            control_q  <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (wr_en && host_req.cs[TGT_SCRATCH])
                scratch_q <= host_req.wdata;
            if (wr_en && host_req.cs[TGT_CONTROL])
                control_q <= host_req.wdata;
            if (mbox_wr && fifo_full)
                overflow_q <= 1'b1;          // word dropped
            else if (wr_en && host_req.cs[TGT_STATUS])
                overflow_q <= 1'b0;          // any write clears
        end
    end

    // ==================================================================
    // read mux
    // ==================================================================
    assign level_field = fifo_level & LEVEL_MASK;
    assign status_word = {overflow_q,
                          {(FSMC_DATA_WIDTH-1-FSMC_FIFO_LEVEL_WIDTH){1'b0}},
                          level_field};

    always_comb begin
        host_rdata = '0;
        if (host_req.cs[TGT_SCRATCH])
            host_rdata = scratch_q;
        else if (host_req.cs[TGT_CONTROL])
            host_rdata = control_q;
        else if (host_req.cs[TGT_STATUS])
            host_rdata = status_word;
        else if (host_req.cs[TGT_MAILBOX])
            host_rdata = fifo_empty ? '0 : fifo_rdata;  // head word, zero if none
    end

endmodule

//--- rtl/fsmc_mailbox_fifo.sv
// ======================================================================
// fsmc mailbox fifo
// circular buffer with level count, drops push when full
// ======================================================================

`timescale 1ns/1ps

module fsmc_mailbox_fifo #(
    parameter int FIFO_DEPTH = 8     // power of two, up to 128
) (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic                                       push,
    input  logic                                       pop,
    input  logic [fsmc_pkg::FSMC_DATA_WIDTH-1:0]       wdata,
    output logic [fsmc_pkg::FSMC_DATA_WIDTH-1:0]       rdata,
    output logic [fsmc_pkg::FSMC_FIFO_LEVEL_WIDTH-1:0] level,
    output logic                                       full,
    output logic                                       empty
);

    import fsmc_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [FSMC_DATA_WIDTH-1:0]       mem [FIFO_DEPTH];   // storage, no reset
    logic [PTR_W-1:0]                 wr_ptr, rd_ptr;
    logic [FSMC_FIFO_LEVEL_WIDTH-1:0] count;
    logic                             do_push, do_pop;

    assign full    = (count == FSMC_FIFO_LEVEL_WIDTH'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // ==================================================================
    // storage
    // ==================================================================
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= wdata;
    end

    assign rdata = mem[rd_ptr];   // head word
    assign level = count;

    // ==================================================================
    // pointers and level
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push+pop together
            endcase
        end
    end

endmodule

//--- rtl/fsmc_slave_top.sv
// ======================================================================
// fsmc slave top
// bus interface, register bank and mailbox fifo
// ======================================================================

`timescale 1ns/1ps

module fsmc_slave_top #(
    parameter int                    ADDR_WIDTH       = 18,
    parameter logic [ADDR_WIDTH-3:0] HIGH_ADDR_CS     = 16'h0040,
    parameter int                    DATA_HOLD_CYCLES = 2,
    parameter int                    FIFO_DEPTH       = 8
) (
    inout  wire  [ADDR_WIDTH-1:0] ad,
    input  logic                  nadv,
    input  logic                  nwe,
    input  logic                  noe,
    input  logic                  clk,
    input  logic                  reset_n
);

    import fsmc_pkg::*;

    fsmc_host_req_t                   host_req;
    logic [FSMC_DATA_WIDTH-1:0]       host_rdata;
    logic                             fifo_push, fifo_pop;
    logic [FSMC_DATA_WIDTH-1:0]       fifo_wdata, fifo_rdata;
    logic [FSMC_FIFO_LEVEL_WIDTH-1:0] fifo_level;
    logic                             fifo_full, fifo_empty;

    // pin side
    fsmc_interface #(
        .ADDR_WIDTH       (ADDR_WIDTH),
        .HIGH_ADDR_CS     (HIGH_ADDR_CS),
        .DATA_HOLD_CYCLES (DATA_HOLD_CYCLES)
    ) i_interface (
        .ad         (ad),
        .nadv       (nadv),
        .nwe        (nwe),
        .noe        (noe),
        .clk        (clk),
        .reset_n    (reset_n),
        .host_rdata (host_rdata),
        .host_req   (host_req)
    );

    fsmc_reg_bank #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_reg_bank (
        .clk        (clk),
        .reset_n    (reset_n),
        .host_req   (host_req),
        .host_rdata (host_rdata),
        .fifo_push  (fifo_push),
        .fifo_pop   (fifo_pop),
        .fifo_wdata (fifo_wdata),
        .fifo_rdata (fifo_rdata),
        .fifo_level (fifo_level),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty)
    );

    // mailbox behind cs3
    fsmc_mailbox_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_mailbox (
        .clk     (clk),
        .reset_n (reset_n),
        .push    (fifo_push),
        .pop     (fifo_pop),
        .wdata   (fifo_wdata),
        .rdata   (fifo_rdata),
        .level   (fifo_level),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

endmodule

//--- tests/fsmc_interface_sva.sv
// ======================================================================
// fsmc interface checks
// chip select shape, AD drive direction, strobe exclusion
// ======================================================================

`timescale 1ns/1ps

module fsmc_interface_sva (
    input logic                                 clk,
    input logic                                 reset_n,
    input logic [fsmc_pkg::FSMC_CS_COUNT-1:0]   cs,
    input fsmc_pkg::fsmc_dir_e                  dir,
    input logic [1:0]                           rd_state,   // 0 is idle, AD released
    input logic                                 wr_strobe,
    input logic                                 rd_done
);

    import fsmc_pkg::*;

    a_cs_onehot: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(cs))
        else $error("chip select is not one-hot: %b", cs);

    // drive only for a read access
    a_drive_on_read: assert property (@(posedge clk) disable iff (!reset_n)
        (rd_state != 2'd0) |-> (dir == DIR_READ))
        else $error("AD driven during a write access");

    a_strobe_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(wr_strobe && rd_done))
        else $error("write strobe and read done high together");

endmodule

bind fsmc_interface fsmc_interface_sva i_interface_sva (
    .clk       (clk),
    .reset_n   (reset_n),
    .cs        (cs_q),
    .dir       (dir_q),
    .rd_state  (rd_state),
    .wr_strobe (wr_strobe_q),
    .rd_done   (rd_done_q)
);

//--- tests/tb_fsmc_slave.sv
// ======================================================================
// fsmc slave testbench
// muxed bus cycles from the mcu side, directed tests on all targets
// ======================================================================

`timescale 1ns/1ps

module tb_fsmc_slave;

    import fsmc_pkg::*;

    localparam int          ADDR_WIDTH      = 18;
    localparam logic [15:0] HIGH_ADDR_CS    = 16'h0040;
    localparam int          FIFO_DEPTH      = 8;
    localparam logic [17:0] AD_FLOAT        = '1;   // idle bus reads as pulled up
    localparam int          RELEASE_TIMEOUT = 20;   // cycles

    logic                  clk = 1'b0;
    logic                  reset_n, nadv, nwe, noe;
    logic                  drive_en;                // mcu side tristate
    logic [ADDR_WIDTH-1:0] drive_val;
    tri1  [ADDR_WIDTH-1:0] ad;

    integer      seed = 32'ha9ca_0e9f;
    int          error_count = 0;
    int          test_errors, test_count = 0, check_count = 0;
    string       test_name;
    logic [15:0] mbox_model[$];   // expected mailbox contents
    logic        ovf_model;

    assign ad = drive_en ? drive_val : 'z;

    always #10 clk = ~clk;

    fsmc_slave_top #(
        .ADDR_WIDTH(ADDR_WIDTH), .HIGH_ADDR_CS(HIGH_ADDR_CS),
        .DATA_HOLD_CYCLES(2), .FIFO_DEPTH(FIFO_DEPTH)
    ) i_dut (
        .ad(ad), .nadv(nadv), .nwe(nwe), .noe(noe), .clk(clk), .reset_n(reset_n)
    );

    // ==================================================================
    // bus cycles
    // ==================================================================
    task automatic apply_reset();
        @(posedge clk);
        #2 reset_n = 1'b0;
        repeat (3) @(posedge clk);
        #2 reset_n = 1'b1;
    endtask

    task automatic bus_write(input logic [17:0] addr, input logic [15:0] data);
        @(posedge clk);
        #2 drive_val = addr;          // address phase
        drive_en = 1'b1;
        nadv     = 1'b0;
        @(posedge clk);
        #2 nadv = 1'b1;
        nwe  = 1'b0;                  // low at nadv rise means write
        @(posedge clk);
        #2 drive_val = {2'b00, data};
        repeat (3) @(posedge clk);
        #2 nwe = 1'b1;                // four cycles low
        repeat (3) @(posedge clk);    // data captured two cycles after rise
        #2 drive_en = 1'b0;
        @(posedge clk);
    endtask

    task automatic bus_read(input logic [17:0] addr, output logic [17:0] data);
        int waited;
        @(posedge clk);
        #2 drive_val = addr;
        drive_en = 1'b1;
        nadv     = 1'b0;
        @(posedge clk);
        #2 nadv = 1'b1;               // nwe stays high for a read
        @(posedge clk);
        #2 drive_en = 1'b0;
        noe = 1'b0;
        repeat (4) @(posedge clk);
        #1 data = ad;                 // just before noe rises
        #1 noe = 1'b1;
        waited = 0;
        while ((ad !== AD_FLOAT) && (waited < RELEASE_TIMEOUT)) begin
            @(posedge clk);
            #2 waited++;
        end
        assert (ad === AD_FLOAT)
        else begin
            $display("%s: AD still driven %0d cycles after noe rose", test_name, waited);
            test_errors++;
        end
        @(posedge clk);               // rd_done and pop settle
    endtask

    function automatic logic [17:0] make_addr(input logic [15:0] high, input fsmc_target_e tgt);
        return {high, tgt};
    endfunction

    // status word has the level in the low byte and sticky overflow in bit 15
    function automatic logic [15:0] status_expected();
        return {ovf_model, 7'b0, 8'(mbox_model.size())};
    endfunction

    task automatic write_reg(input fsmc_target_e tgt, input logic [15:0] data);
        bus_write(make_addr(HIGH_ADDR_CS, tgt), data);
    endtask

    task automatic read_reg(input fsmc_target_e tgt, output logic [17:0] data);
        bus_read(make_addr(HIGH_ADDR_CS, tgt), data);
    endtask

    // ==================================================================
    // checking and reporting
    // ==================================================================
    task automatic check_bus(input string what, input logic [17:0] expected,
                             input logic [17:0] actual);
        check_count++;
        assert (actual === expected)
        else begin
            $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_word(input string what, input logic [15:0] expected,
                              input logic [17:0] actual);
        check_bus(what, {2'b00, expected}, actual);   // upper AD bits read as zero
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        test_count++;
        error_count += test_errors;
        if (test_errors == 0)
            $display("test %s passed", test_name);
        else
            $display("test %s failed with %0d mismatches", test_name, test_errors);
    endtask

    // ==================================================================
    // tests
    // ==================================================================
    task automatic test_scratch();
        logic [17:0] rd;
        logic [15:0] word;
        start_test("scratch");
        for (int i = 0; i < 4; i++) begin
            word = 16'($random(seed));
            write_reg(TGT_SCRATCH, word);
            read_reg(TGT_SCRATCH, rd);
            check_word("scratch readback", word, rd);
        end
        for (int i = 0; i < 2; i++) begin
            word = 16'($random(seed));
            write_reg(TGT_CONTROL, word);
            read_reg(TGT_CONTROL, rd);
            check_word("control readback", word, rd);
        end
        write_reg(TGT_CONTROL, 16'h0000);   // mailbox off again
        finish_test();
    endtask

    task automatic test_decode();
        logic [17:0] rd;
        logic [15:0] word;
        start_test("decode");
        word = 16'($random(seed));
        write_reg(TGT_SCRATCH, word);
        bus_write(make_addr(HIGH_ADDR_CS + 16'h1, TGT_SCRATCH), ~word);
        bus_read(make_addr(HIGH_ADDR_CS + 16'h1, TGT_SCRATCH), rd);
        check_bus("foreign read leaves AD floating", AD_FLOAT, rd);
        read_reg(TGT_SCRATCH, rd);
        check_word("scratch after foreign write", word, rd);
        finish_test();
    endtask

    task automatic test_mailbox_order();
        logic [17:0] rd;
        logic [15:0] word;
        start_test("mailbox_order");
        write_reg(TGT_CONTROL, 16'h0001);
        for (int i = 0; i < 3; i++) begin
            word = 16'($random(seed));
            write_reg(TGT_MAILBOX, word);
            mbox_model.push_back(word);
        end
        for (int i = 0; i < 3; i++) begin
            read_reg(TGT_STATUS, rd);
            check_word("status level", status_expected(), rd);
            read_reg(TGT_MAILBOX, rd);
            check_word("mailbox pop", mbox_model.pop_front(), rd);
        end
        read_reg(TGT_STATUS, rd);
        check_word("status level", status_expected(), rd);
        finish_test();
    endtask

    task automatic test_overflow();
        logic [17:0] rd;
        logic [15:0] word;
        start_test("overflow");
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            word = 16'($random(seed));
            write_reg(TGT_MAILBOX, word);
            if (mbox_model.size() < FIFO_DEPTH)
                mbox_model.push_back(word);
            else
                ovf_model = 1'b1;         // last word dropped
        end
        read_reg(TGT_STATUS, rd);
        check_word("status when full", status_expected(), rd);
        write_reg(TGT_STATUS, 16'h0000);  // any write clears the flag
        ovf_model = 1'b0;
        read_reg(TGT_STATUS, rd);
        check_word("status after clear", status_expected(), rd);
        while (mbox_model.size() > 0) begin
            read_reg(TGT_MAILBOX, rd);
            check_word("drain order", mbox_model.pop_front(), rd);
        end
        finish_test();
    endtask

    task automatic test_gating();
        logic [17:0] rd;
        start_test("gating");
        write_reg(TGT_CONTROL, 16'h0000);
        write_reg(TGT_MAILBOX, 16'(($random(seed))));
        write_reg(TGT_MAILBOX, 16'(($random(seed))));
        read_reg(TGT_STATUS, rd);
        check_word("level with mailbox off", 16'h0000, rd);
        read_reg(TGT_MAILBOX, rd);
        check_word("empty mailbox read", 16'h0000, rd);
        finish_test();
    endtask

    task automatic test_reset_state();
        logic [17:0] rd;
        start_test("reset_state");
        write_reg(TGT_SCRATCH, 16'h5a5a);
        write_reg(TGT_CONTROL, 16'h0001);
        write_reg(TGT_MAILBOX, 16'h1234);
        apply_reset();
        mbox_model.delete();
        ovf_model = 1'b0;
        for (int t = 0; t < FSMC_CS_COUNT; t++) begin
            read_reg(fsmc_target_e'(t), rd);
            check_word("target after reset", 16'h0000, rd);
        end
        finish_test();
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin
        reset_n   = 1'b0;
        nadv      = 1'b1;
        nwe       = 1'b1;
        noe       = 1'b1;
        drive_en  = 1'b0;
        drive_val = '0;
        ovf_model = 1'b0;
        apply_reset();
        test_scratch();
        test_decode();
        test_mailbox_order();
        test_overflow();
        test_gating();
        test_reset_state();
        $display("tests: %0d, checks: %0d, mismatches: %0d",
                 test_count, check_count, error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- build.f
common/fsmc_pkg.sv
fsmc/fsmc_interface.sv
rtl/fsmc_reg_bank.sv
rtl/fsmc_mailbox_fifo.sv
rtl/fsmc_slave_top.sv
tests/fsmc_interface_sva.sv
tests/tb_fsmc_slave.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fsmc slave testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_fsmc_slave \
    --Mdir obj_dir -o tb_fsmc_slave > build.log 2>&1 &&
./obj_dir/tb_fsmc_slave > sim.log 2>&1 ||
echo "build or simulation returned an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && echo "run_sim: pass" && exit 0 ||
{ echo "run_sim: fail"; exit 1; }
